// ==== hdl/merge_data_defines.svh ====
`ifndef MERGE_DATA_DEFINES_SVH
`define MERGE_DATA_DEFINES_SVH

// ---------------------------------------------------------------------
// Packet field widths
// ---------------------------------------------------------------------
// Payload of one response
`define MERGE_DATA_W 32
`define MERGE_ID_W 8
// Pairs per run
`define MERGE_COUNT_W 16

// ---------------------------------------------------------------------
// FIFO sizing
// ---------------------------------------------------------------------
`define MERGE_FIFO_DEPTH 16
// Leaves headroom for strobes already in flight
`define MERGE_PROG_THRESH 12

`endif

// ==== hdl/merge_data_pkg.sv ====
`include "merge_data_defines.svh"

package merge_data_pkg;

    // -----------------------------------------------------------------
    // Response side
    // -----------------------------------------------------------------
    typedef logic [`MERGE_DATA_W-1:0] response_data_t;
    typedef logic [`MERGE_ID_W-1:0] response_id_t;
    // Id in the upper bits, payload below
    typedef logic [`MERGE_ID_W+`MERGE_DATA_W-1:0] response_word_t;
    typedef logic [`MERGE_COUNT_W-1:0] merge_count_t;

    // -----------------------------------------------------------------
    // Request side
    // -----------------------------------------------------------------
    // Engine payload high, memory payload low
    typedef logic [2*`MERGE_DATA_W-1:0] merged_data_t;
    typedef logic [`MERGE_ID_W+2*`MERGE_DATA_W-1:0] request_word_t;

    typedef enum logic [2:0] {
        GEN_IDLE,
        GEN_PAIR,
        GEN_WAIT,
        GEN_PUSH,
        GEN_DONE
    } generator_state_t;

endpackage : merge_data_pkg

// ==== hdl/merge_data_fifo.sv ====
`timescale 1ns/10ps

module merge_data_fifo #(
    parameter int DATA_W      = 32,
    parameter int DEPTH       = 16,
    parameter int PROG_THRESH = 12
) (
    input  logic              ap_clk,
    input  logic              areset_csr_engine,
    input  logic              wr_en_i,
    input  logic [DATA_W-1:0] din_i,
    input  logic              rd_en_i,
    output logic [DATA_W-1:0] dout_o,
    output logic              valid_o,
    output logic              empty_o,
    output logic              full_o,
    output logic              prog_full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              wr_accept;
    logic              rd_accept;

    // Write when full and read when empty are dropped
    assign wr_accept = wr_en_i & ~full_o;
    assign rd_accept = rd_en_i & ~empty_o;

    assign empty_o     = (count == '0);
    assign full_o      = (count == CNT_W'(DEPTH));
    assign prog_full_o = (count >= CNT_W'(PROG_THRESH));

    // -----------------------------------------------------------------
    // Pointers, occupancy and read valid
    // -----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= rd_accept;
            if (wr_accept) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_accept) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_accept, rd_accept})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= din_i;
        end
        if (rd_accept) begin
            dout_o <= mem[rd_ptr];
        end
    end

endmodule : merge_data_fifo

// ==== hdl/merge_data_input.sv ====
`timescale 1ns/10ps
`include "merge_data_defines.svh"

module merge_data_input (
    input  logic                           ap_clk,
    input  logic                           areset_csr_engine,
    input  logic                           response_engine_valid_i,
    input  merge_data_pkg::response_id_t   response_engine_id_i,
    input  merge_data_pkg::response_data_t response_engine_data_i,
    input  logic                           response_memory_valid_i,
    input  merge_data_pkg::response_id_t   response_memory_id_i,
    input  merge_data_pkg::response_data_t response_memory_data_i,
    output logic                           response_engine_prog_full_o,
    output logic                           response_memory_prog_full_o,
    input  logic                           engine_pop_i,
    input  logic                           memory_pop_i,
    output logic                           engine_empty_o,
    output logic                           memory_empty_o,
    output logic                           engine_valid_o,
    output logic                           memory_valid_o,
    output merge_data_pkg::response_word_t engine_word_o,
    output merge_data_pkg::response_word_t memory_word_o
);

    logic                           engine_valid_reg;
    logic                           memory_valid_reg;
    merge_data_pkg::response_word_t engine_word_reg;
    merge_data_pkg::response_word_t memory_word_reg;

    // -----------------------------------------------------------------
    // Input registers
    // -----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            engine_valid_reg <= 1'b0;
            memory_valid_reg <= 1'b0;
        end else begin
            engine_valid_reg <= response_engine_valid_i;
            memory_valid_reg <= response_memory_valid_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        engine_word_reg <= {response_engine_id_i, response_engine_data_i};
        memory_word_reg <= {response_memory_id_i, response_memory_data_i};
    end

    // -----------------------------------------------------------------
    // Response FIFOs
    // -----------------------------------------------------------------
    merge_data_fifo #(
        .DATA_W     ($bits(merge_data_pkg::response_word_t)),
        .DEPTH      (`MERGE_FIFO_DEPTH                     ),
        .PROG_THRESH(`MERGE_PROG_THRESH                    )
    ) engine_fifo_i (
        .ap_clk           (ap_clk                     ),
        .areset_csr_engine(areset_csr_engine          ),
        .wr_en_i          (engine_valid_reg           ),
        .din_i            (engine_word_reg            ),
        .rd_en_i          (engine_pop_i               ),
        .dout_o           (engine_word_o              ),
        .valid_o          (engine_valid_o             ),
        .empty_o          (engine_empty_o             ),
        .full_o           (                           ),
        .prog_full_o      (response_engine_prog_full_o)
    );

    merge_data_fifo #(
        .DATA_W     ($bits(merge_data_pkg::response_word_t)),
        .DEPTH      (`MERGE_FIFO_DEPTH                     ),
        .PROG_THRESH(`MERGE_PROG_THRESH                    )
    ) memory_fifo_i (
        .ap_clk           (ap_clk                     ),
        .areset_csr_engine(areset_csr_engine          ),
        .wr_en_i          (memory_valid_reg           ),
        .din_i            (memory_word_reg            ),
        .rd_en_i          (memory_pop_i               ),
        .dout_o           (memory_word_o              ),
        .valid_o          (memory_valid_o             ),
        .empty_o          (memory_empty_o             ),
        .full_o           (                           ),
        .prog_full_o      (response_memory_prog_full_o)
    );

endmodule : merge_data_input

// ==== hdl/merge_data_generator.sv ====
`timescale 1ns/10ps
`include "merge_data_defines.svh"

module merge_data_generator (
    input  logic                           ap_clk,
    input  logic                           areset_csr_engine,
    input  logic                           descriptor_valid_i,
    input  merge_data_pkg::merge_count_t   descriptor_count_i,
    input  logic                           engine_empty_i,
    input  logic                           engine_valid_i,
    input  merge_data_pkg::response_word_t engine_word_i,
    input  logic                           memory_empty_i,
    input  logic                           memory_valid_i,
    input  merge_data_pkg::response_word_t memory_word_i,
    output logic                           engine_pop_o,
    output logic                           memory_pop_o,
    input  logic                           out_prog_full_i,
    output logic                           push_o,
    output merge_data_pkg::request_word_t  push_word_o,
    output logic                           done_o
);

    merge_data_pkg::generator_state_t state;
    merge_data_pkg::generator_state_t next_state;
    merge_data_pkg::merge_count_t     remaining;
    logic                             pair_ready;
    logic                             pair_valid;

    // Both heads present and room downstream
    assign pair_ready = ~engine_empty_i & ~memory_empty_i & ~out_prog_full_i;
    assign pair_valid = engine_valid_i & memory_valid_i;

    // Streams always popped together to keep arrival order paired
    assign engine_pop_o = (state == merge_data_pkg::GEN_PAIR) & pair_ready;
    assign memory_pop_o = (state == merge_data_pkg::GEN_PAIR) & pair_ready;
    assign push_o       = (state == merge_data_pkg::GEN_PUSH);

    // -----------------------------------------------------------------
    // Next state
    // -----------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            merge_data_pkg::GEN_IDLE: begin
                if (descriptor_valid_i) begin
                    next_state = (descriptor_count_i == '0) ? merge_data_pkg::GEN_DONE
                                                            : merge_data_pkg::GEN_PAIR;
                end
            end
            merge_data_pkg::GEN_PAIR: begin
                if (pair_ready) begin
                    next_state = merge_data_pkg::GEN_WAIT;
                end
            end
            merge_data_pkg::GEN_WAIT: begin
                if (pair_valid) begin
                    next_state = merge_data_pkg::GEN_PUSH;
                end
            end
            merge_data_pkg::GEN_PUSH: begin
                next_state = (remaining == '0) ? merge_data_pkg::GEN_DONE
                                               : merge_data_pkg::GEN_PAIR;
            end
            default: next_state = merge_data_pkg::GEN_IDLE;
        endcase
    end

    // -----------------------------------------------------------------
    // State, pair counter and done
    // -----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state     <= merge_data_pkg::GEN_IDLE;
            remaining <= '0;
            done_o    <= 1'b1;
        end else begin
            state <= next_state;
            if (state == merge_data_pkg::GEN_IDLE && descriptor_valid_i) begin
                remaining <= descriptor_count_i;
                done_o    <= 1'b0;
            end
            if (state == merge_data_pkg::GEN_WAIT && pair_valid) begin
                remaining <= remaining - 1'b1;
            end
            if (state == merge_data_pkg::GEN_DONE) begin
                done_o <= 1'b1;
            end
        end
    end

    // Engine id and payload, then memory payload
    always_ff @(posedge ap_clk) begin
        if (pair_valid) begin
            push_word_o <= {engine_word_i, memory_word_i[`MERGE_DATA_W-1:0]};
        end
    end

endmodule : merge_data_generator

// ==== hdl/merge_data_output.sv ====
`timescale 1ns/10ps
`include "merge_data_defines.svh"

module merge_data_output (
    input  logic                          ap_clk,
    input  logic                          areset_csr_engine,
    input  logic                          push_i,
    input  merge_data_pkg::request_word_t push_word_i,
    output logic                          prog_full_o,
    input  logic                          request_rd_en_i,
    output logic                          request_valid_o,
    output merge_data_pkg::response_id_t  request_id_o,
    output merge_data_pkg::merged_data_t  request_data_o
);

    logic                          fifo_rd_en;
    logic                          fifo_empty;
    logic                          fifo_valid;
    merge_data_pkg::request_word_t fifo_dout;

    // Drain under the downstream read level
    assign fifo_rd_en = ~fifo_empty & request_rd_en_i;

    merge_data_fifo #(
        .DATA_W     ($bits(merge_data_pkg::request_word_t)),
        .DEPTH      (`MERGE_FIFO_DEPTH                    ),
        .PROG_THRESH(`MERGE_PROG_THRESH                   )
    ) request_fifo_i (
        .ap_clk           (ap_clk           ),
        .areset_csr_engine(areset_csr_engine),
        .wr_en_i          (push_i           ),
        .din_i            (push_word_i      ),
        .rd_en_i          (fifo_rd_en       ),
        .dout_o           (fifo_dout        ),
        .valid_o          (fifo_valid       ),
        .empty_o          (fifo_empty       ),
        .full_o           (                 ),
        .prog_full_o      (prog_full_o      )
    );

    // -----------------------------------------------------------------
    // Output registers
    // -----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            request_valid_o <= 1'b0;
        end else begin
            request_valid_o <= fifo_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_id_o   <= fifo_dout[`MERGE_ID_W+2*`MERGE_DATA_W-1 -: `MERGE_ID_W];
        request_data_o <= fifo_dout[2*`MERGE_DATA_W-1:0];
    end

endmodule : merge_data_output

// ==== hdl/engine_merge_data.sv ====
`timescale 1ns/10ps

module engine_merge_data (
    input  logic                           ap_clk,
    input  logic                           areset_i,
    input  logic                           descriptor_valid_i,
    input  merge_data_pkg::merge_count_t   descriptor_count_i,
    input  logic                           response_engine_valid_i,
    input  merge_data_pkg::response_id_t   response_engine_id_i,
    input  merge_data_pkg::response_data_t response_engine_data_i,
    output logic                           response_engine_prog_full_o,
    input  logic                           response_memory_valid_i,
    input  merge_data_pkg::response_id_t   response_memory_id_i,
    input  merge_data_pkg::response_data_t response_memory_data_i,
    output logic                           response_memory_prog_full_o,
    input  logic                           request_rd_en_i,
    output logic                           request_valid_o,
    output merge_data_pkg::response_id_t   request_id_o,
    output merge_data_pkg::merged_data_t   request_data_o,
    output logic                           done_o
);

    logic                           areset_csr_engine;
    logic                           descriptor_valid_reg;
    merge_data_pkg::merge_count_t   descriptor_count_reg;
    logic                           engine_pop;
    logic                           memory_pop;
    logic                           engine_empty;
    logic                           memory_empty;
    logic                           engine_valid;
    logic                           memory_valid;
    merge_data_pkg::response_word_t engine_word;
    merge_data_pkg::response_word_t memory_word;
    logic                           push;
    merge_data_pkg::request_word_t  push_word;
    logic                           out_prog_full;

    // -----------------------------------------------------------------
    // Reset and descriptor registers
    // -----------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_csr_engine <= areset_i;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            descriptor_valid_reg <= 1'b0;
        end else begin
            descriptor_valid_reg <= descriptor_valid_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_count_reg <= descriptor_count_i;
    end

    // -----------------------------------------------------------------
    // Input side, generator, output side
    // -----------------------------------------------------------------
    merge_data_input input_i (
        .ap_clk                     (ap_clk                     ),
        .areset_csr_engine          (areset_csr_engine          ),
        .response_engine_valid_i    (response_engine_valid_i    ),
        .response_engine_id_i       (response_engine_id_i       ),
        .response_engine_data_i     (response_engine_data_i     ),
        .response_memory_valid_i    (response_memory_valid_i    ),
        .response_memory_id_i       (response_memory_id_i       ),
        .response_memory_data_i     (response_memory_data_i     ),
        .response_engine_prog_full_o(response_engine_prog_full_o),
        .response_memory_prog_full_o(response_memory_prog_full_o),
        .engine_pop_i               (engine_pop                 ),
        .memory_pop_i               (memory_pop                 ),
        .engine_empty_o             (engine_empty               ),
        .memory_empty_o             (memory_empty               ),
        .engine_valid_o             (engine_valid               ),
        .memory_valid_o             (memory_valid               ),
        .engine_word_o              (engine_word                ),
        .memory_word_o              (memory_word                )
    );

    merge_data_generator generator_i (
        .ap_clk            (ap_clk              ),
        .areset_csr_engine (areset_csr_engine   ),
        .descriptor_valid_i(descriptor_valid_reg),
        .descriptor_count_i(descriptor_count_reg),
        .engine_empty_i    (engine_empty        ),
        .engine_valid_i    (engine_valid        ),
        .engine_word_i     (engine_word         ),
        .memory_empty_i    (memory_empty        ),
        .memory_valid_i    (memory_valid        ),
        .memory_word_i     (memory_word         ),
        .engine_pop_o      (engine_pop          ),
        .memory_pop_o      (memory_pop          ),
        .out_prog_full_i   (out_prog_full       ),
        .push_o            (push                ),
        .push_word_o       (push_word           ),
        .done_o            (done_o              )
    );

    merge_data_output output_i (
        .ap_clk           (ap_clk           ),
        .areset_csr_engine(areset_csr_engine),
        .push_i           (push             ),
        .push_word_i      (push_word        ),
        .prog_full_o      (out_prog_full    ),
        .request_rd_en_i  (request_rd_en_i  ),
        .request_valid_o  (request_valid_o  ),
        .request_id_o     (request_id_o     ),
        .request_data_o   (request_data_o   )
    );

endmodule : engine_merge_data

// ==== verification/engine_merge_data_tests.svh ====
// Model queues of every response sent
merge_data_pkg::response_word_t engine_model_q[$];
merge_data_pkg::response_word_t memory_model_q[$];
// Responses still to be driven and the idle cycles after each
merge_data_pkg::response_word_t engine_send_q[$];
merge_data_pkg::response_word_t memory_send_q[$];
int                             engine_gap_q[$];
int                             memory_gap_q[$];
int                             pair_index = 0;

// ----------------------------------------------------------------------
// Stimulus helpers
// ----------------------------------------------------------------------
task automatic prepare_pairs(input int count, input bit random_data, input int gap_max);
    merge_data_pkg::response_id_t   id;
    merge_data_pkg::response_data_t engine_data;
    merge_data_pkg::response_data_t memory_data;
    int                             i;
    for (i = 0; i < count; i++) begin
        id = pair_index[7:0];
        if (random_data) begin
            engine_data = $random(seed);
            memory_data = $random(seed);
        end else begin
            engine_data = 32'hE000_0000 | 32'(pair_index);
            memory_data = 32'h4D00_0000 | 32'(pair_index);
        end
        // Memory id differs so a request must carry the engine id
        engine_send_q.push_back({id, engine_data});
        memory_send_q.push_back({~id, memory_data});
        engine_model_q.push_back({id, engine_data});
        memory_model_q.push_back({~id, memory_data});
        if (gap_max == 0) begin
            engine_gap_q.push_back(0);
            memory_gap_q.push_back(0);
        end else begin
            engine_gap_q.push_back($unsigned($random(seed)) % (gap_max + 1));
            memory_gap_q.push_back($unsigned($random(seed)) % (gap_max + 1));
        end
        pair_index++;
    end
endtask

task automatic drive_response(input bit to_memory, input logic valid,
                              input merge_data_pkg::response_word_t word);
    if (to_memory) begin
        response_memory_valid_i <= valid;
        response_memory_id_i    <= word[`MERGE_DATA_W +: `MERGE_ID_W];
        response_memory_data_i  <= word[`MERGE_DATA_W-1:0];
    end else begin
        response_engine_valid_i <= valid;
        response_engine_id_i    <= word[`MERGE_DATA_W +: `MERGE_ID_W];
        response_engine_data_i  <= word[`MERGE_DATA_W-1:0];
    end
endtask

// Source holds off while the matching prog-full is high
task automatic send_stream(input bit to_memory);
    merge_data_pkg::response_word_t word;
    logic                           stalled;
    int                             gap;
    while ((to_memory ? memory_send_q.size() : engine_send_q.size()) > 0) begin
        @(negedge ap_clk);
        stalled = to_memory ? response_memory_prog_full_o : response_engine_prog_full_o;
        @(posedge ap_clk);
        if (stalled) begin
            drive_response(to_memory, 1'b0, '0);
        end else begin
            if (to_memory) begin
                word = memory_send_q.pop_front();
                gap  = memory_gap_q.pop_front();
            end else begin
                word = engine_send_q.pop_front();
                gap  = engine_gap_q.pop_front();
            end
            drive_response(to_memory, 1'b1, word);
            repeat (gap) begin
                @(posedge ap_clk);
                drive_response(to_memory, 1'b0, word);
            end
        end
    end
    @(posedge ap_clk);
    drive_response(to_memory, 1'b0, '0);
endtask

// done_o falls two edges after the strobe because of the descriptor register
task automatic send_descriptor(input int count);
    @(posedge ap_clk);
    descriptor_valid_i <= 1'b1;
    descriptor_count_i <= count[`MERGE_COUNT_W-1:0];
    @(posedge ap_clk);
    descriptor_valid_i <= 1'b0;
    @(posedge ap_clk);
    @(negedge ap_clk);
    check_value("done_o", 64'(done_o), 64'h0);
endtask

task automatic wait_run_done();
    @(negedge ap_clk);
    while (done_o !== 1'b1 || engine_model_q.size() > 0) begin
        @(negedge ap_clk);
    end
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic verify_reset_values();
    @(negedge ap_clk);
    check_value("done_o", 64'(done_o), 64'h1);
    check_value("request_valid_o", 64'(request_valid_o), 64'h0);
    check_value("response_engine_prog_full_o", 64'(response_engine_prog_full_o), 64'h0);
    check_value("response_memory_prog_full_o", 64'(response_memory_prog_full_o), 64'h0);
endtask

task automatic merge_lockstep_pairs();
    prepare_pairs(4, 1'b0, 0);
    send_descriptor(4);
    fork
        send_stream(1'b0);
        send_stream(1'b1);
    join
    wait_run_done();
endtask

task automatic merge_skewed_streams();
    prepare_pairs(8, 1'b0, 0);
    send_descriptor(8);
    send_stream(1'b0);
    // Memory side long after the engine side
    repeat (40) @(posedge ap_clk);
    send_stream(1'b1);
    wait_run_done();
endtask

task automatic hold_back_requests();
    @(posedge ap_clk);
    request_rd_en_i <= 1'b0;
    prepare_pairs(30, 1'b0, 0);
    send_descriptor(30);
    fork
        send_stream(1'b0);
        send_stream(1'b1);
        begin
            // Stall must reach back to both sources
            while (!(response_engine_prog_full_o && response_memory_prog_full_o)) begin
                @(negedge ap_clk);
            end
            @(posedge ap_clk);
            request_rd_en_i <= 1'b1;
        end
    join
    wait_run_done();
endtask

task automatic mix_random_traffic();
    prepare_pairs(40, 1'b1, 3);
    send_descriptor(40);
    fork
        send_stream(1'b0);
        send_stream(1'b1);
        begin
            while (engine_model_q.size() > 0) begin
                @(posedge ap_clk);
                request_rd_en_i <= (($random(seed) & 3) != 0);
            end
            request_rd_en_i <= 1'b1;
        end
    join
    wait_run_done();
endtask

task automatic send_zero_count();
    int waited;
    send_descriptor(0);
    waited = 0;
    while (done_o !== 1'b1 && waited < 4) begin
        @(negedge ap_clk);
        waited++;
    end
    if (done_o !== 1'b1) begin
        stop_with_failure("done_o did not return high after a zero-count descriptor");
    end
    // No request may follow a zero-count run
    repeat (8) @(negedge ap_clk);
endtask

// ==== verification/engine_merge_data_tb.sv ====
`timescale 1ns/10ps
`include "merge_data_defines.svh"

module engine_merge_data_tb;

    // Budget of 200 cycles per expected request over all tests
    localparam int EXPECTED_PACKETS = 82;
    localparam int WATCHDOG_CYCLES  = 200 * EXPECTED_PACKETS;

    logic                           ap_clk;
    logic                           areset_i;
    logic                           descriptor_valid_i;
    merge_data_pkg::merge_count_t   descriptor_count_i;
    logic                           response_engine_valid_i;
    merge_data_pkg::response_id_t   response_engine_id_i;
    merge_data_pkg::response_data_t response_engine_data_i;
    logic                           response_engine_prog_full_o;
    logic                           response_memory_valid_i;
    merge_data_pkg::response_id_t   response_memory_id_i;
    merge_data_pkg::response_data_t response_memory_data_i;
    logic                           response_memory_prog_full_o;
    logic                           request_rd_en_i;
    logic                           request_valid_o;
    merge_data_pkg::response_id_t   request_id_o;
    merge_data_pkg::merged_data_t   request_data_o;
    logic                           done_o;
    integer                         seed;
    merge_data_pkg::response_word_t head_engine;
    merge_data_pkg::response_word_t head_memory;

    `include "engine_merge_data_tests.svh"

    engine_merge_data dut_i (.*);

    initial ap_clk = 1'b0;
    always #4 ap_clk = ~ap_clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h",
                                        name, actual, expected));
        end
    endtask

    // ------------------------------------------------------------------
    // Request checker against the model heads in arrival order
    // ------------------------------------------------------------------
    always @(negedge ap_clk) begin
        if (request_valid_o === 1'b1) begin
            if (engine_model_q.size() == 0 || memory_model_q.size() == 0) begin
                stop_with_failure("A request arrived with no pair left to match it");
            end else begin
                head_engine = engine_model_q.pop_front();
                head_memory = memory_model_q.pop_front();
                check_value("request_id_o", 64'(request_id_o),
                            64'(head_engine[`MERGE_DATA_W +: `MERGE_ID_W]));
                check_value("request_data_o", request_data_o,
                            {head_engine[`MERGE_DATA_W-1:0], head_memory[`MERGE_DATA_W-1:0]});
            end
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        stop_with_failure("Timeout: the tests did not finish within the cycle budget");
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        seed                    = 32'h66adf261;
        areset_i                = 1'b1;
        descriptor_valid_i      = 1'b0;
        descriptor_count_i      = '0;
        response_engine_valid_i = 1'b0;
        response_engine_id_i    = '0;
        response_engine_data_i  = '0;
        response_memory_valid_i = 1'b0;
        response_memory_id_i    = '0;
        response_memory_data_i  = '0;
        request_rd_en_i         = 1'b1;
        repeat (4) @(posedge ap_clk);
        areset_i <= 1'b0;
        // Internal reset is one register behind
        repeat (2) @(posedge ap_clk);
        verify_reset_values();
        merge_lockstep_pairs();
        merge_skewed_streams();
        hold_back_requests();
        mix_random_traffic();
        send_zero_count();
        $display("RESULT: PASS");
        $finish;
    end

endmodule : engine_merge_data_tb

// ==== engine_merge_data.f ====
+incdir+hdl
+incdir+verification
hdl/merge_data_pkg.sv
hdl/merge_data_fifo.sv
hdl/merge_data_input.sv
hdl/merge_data_generator.sv
hdl/merge_data_output.sv
hdl/engine_merge_data.sv
verification/engine_merge_data_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps
TOP       = engine_merge_data_tb
FILELIST  = engine_merge_data.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
